//--- source/qracc_pkg.sv
/* Shared widths, buffer sizes, controller state encoding and
   the packed configuration, control and bus structs */
`default_nettype none

package qracc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath and memory sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int act_width      = 8;
    localparam int acc_width      = 24;
    localparam int bus_width      = 32;
    localparam int elems_per_word = bus_width / act_width;
    localparam int act_depth      = 256;
    localparam int act_addr_width = $clog2(act_depth);
    localparam int max_taps       = 16;
    localparam int wt_addr_width  = $clog2(max_taps);

    // Sequencer states, same order as the host sequence
    typedef enum logic [2:0] {
        s_idle         = 3'd0,
        s_load_weights = 3'd1,
        s_load_acts    = 3'd2,
        s_load_scaler  = 3'd3,
        s_compute      = 3'd4,
        s_read_acts    = 3'd5
    } qracc_state_t;

    // Convolution shape, held by the host while busy
    typedef struct packed {
        logic [3:0] ifmap_dimx;
        logic [3:0] ifmap_dimy;
        logic [2:0] filter_x;
        logic [2:0] filter_y;
    } qracc_cfg_t;

    // Per-cycle control from the sequencer
    typedef struct packed {
        logic                      act_ext_wr_en;
        logic [act_addr_width-1:0] act_ext_wr_addr;
        logic                      act_rd_en;
        logic [act_addr_width-1:0] act_rd_addr;
        logic [act_addr_width-1:0] act_int_wr_addr;
        logic                      wt_wr_en;
        logic [wt_addr_width-1:0]  wt_wr_addr;
        logic [wt_addr_width-1:0]  wt_rd_addr;
        logic                      tap_valid;
        logic                      tap_last;
        logic                      scaler_wr_en;
    } qracc_ctrl_t;

    // Host data bus request
    typedef struct packed {
        logic                 valid;
        logic                 wen;
        logic [bus_width-1:0] wdata;
    } qracc_bus_t;

endpackage

`default_nettype wire

//--- source/qracc_controller.sv
/* Sequencing FSM with load pointers, convolution window counters
   and the per-state control decode */
`default_nettype none

module qracc_controller import qracc_pkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  qracc_cfg_t   cfg_i,
    input  logic         start_i,
    input  logic         clear_i,
    input  qracc_bus_t   bus_i,
    input  logic         result_valid_i,
    output qracc_ctrl_t  ctrl_o,
    output logic         bus_rd_valid_o,
    output logic         busy_o
);

    logic bus_wr;
    logic bus_rd;
    logic [3:0] out_x;
    logic [3:0] out_y;
    logic [4:0] n_taps;
    logic [act_addr_width-1:0] ifmap_size;
    logic [act_addr_width-1:0] n_out;
    qracc_state_t state_q;
    qracc_state_t state_d;
    logic [wt_addr_width-1:0] wt_ptr_q;
    logic [act_addr_width-1:0] act_wr_ptr_q;
    logic [act_addr_width-1:0] ofmap_start_q;
    logic [act_addr_width-1:0] out_ptr_q;
    logic [act_addr_width-1:0] rd_ptr_q;
    logic [2:0] fx_q;
    logic [2:0] fy_q;
    logic [3:0] ox_q;
    logic [3:0] oy_q;
    logic issue_done_q;
    logic issuing;
    logic window_end;
    logic tap_valid_q;
    logic tap_last_q;
    logic bus_rd_valid_q;
    logic leaving;
    logic [act_addr_width-1:0] ifmap_rd_addr;
    logic [wt_addr_width-1:0] weight_rd_addr;

    assign bus_wr     = bus_i.valid && bus_i.wen;
    assign bus_rd     = bus_i.valid && !bus_i.wen;
    assign out_x      = cfg_i.ifmap_dimx - 4'(cfg_i.filter_x) + 4'd1;
    assign out_y      = cfg_i.ifmap_dimy - 4'(cfg_i.filter_y) + 4'd1;
    assign n_taps     = 5'(cfg_i.filter_x) * 5'(cfg_i.filter_y);
    assign ifmap_size = act_addr_width'(cfg_i.ifmap_dimx) * act_addr_width'(cfg_i.ifmap_dimy);
    assign n_out      = act_addr_width'(out_x) * act_addr_width'(out_y);
    assign issuing    = (state_q == s_compute) && !issue_done_q;
    assign window_end = (fx_q == cfg_i.filter_x - 3'd1) && (fy_q == cfg_i.filter_y - 3'd1);
    assign leaving    = (state_d != state_q);
    assign busy_o     = (state_q != s_idle);
    assign bus_rd_valid_o = bus_rd_valid_q;

    // (oy+fy)*dimx + ox + fx and fy*filter_x + fx
    assign ifmap_rd_addr = act_addr_width'(oy_q + 4'(fy_q)) * act_addr_width'(cfg_i.ifmap_dimx)
                         + act_addr_width'(ox_q) + act_addr_width'(fx_q);
    assign weight_rd_addr = wt_addr_width'(fy_q) * wt_addr_width'(cfg_i.filter_x)
                          + wt_addr_width'(fx_q);

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            s_idle:         if (start_i) state_d = s_load_weights;
            s_load_weights: if (bus_wr && {1'b0, wt_ptr_q} == n_taps - 5'd1)
                                state_d = s_load_acts;
            s_load_acts:    if (bus_wr && act_wr_ptr_q + act_addr_width'(elems_per_word) >= ifmap_size)
                                state_d = s_load_scaler;
            s_load_scaler:  if (bus_wr) state_d = s_compute;
            s_compute:      if (result_valid_i && out_ptr_q == n_out - 1'b1)
                                state_d = s_read_acts;
            s_read_acts:    if (bus_rd && rd_ptr_q == n_out - 1'b1) state_d = s_idle;
            default:        state_d = s_idle;
        endcase
        if (clear_i) state_d = s_idle;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= s_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Control decode, everything inactive by default
    always_comb begin
        ctrl_o = '0;
        ctrl_o.tap_valid       = tap_valid_q;
        ctrl_o.tap_last        = tap_last_q;
        ctrl_o.act_int_wr_addr = ofmap_start_q + out_ptr_q;
        case (state_q)
            s_load_weights: begin
                ctrl_o.wt_wr_en   = bus_wr;
                ctrl_o.wt_wr_addr = wt_ptr_q;
            end
            s_load_acts: begin
                ctrl_o.act_ext_wr_en   = bus_wr;
                ctrl_o.act_ext_wr_addr = act_wr_ptr_q;
            end
            s_load_scaler: ctrl_o.scaler_wr_en = bus_wr;
            s_compute: begin
                ctrl_o.act_rd_en   = issuing;
                ctrl_o.act_rd_addr = ifmap_rd_addr;
                ctrl_o.wt_rd_addr  = weight_rd_addr;
            end
            s_read_acts: begin
                ctrl_o.act_rd_en   = bus_rd;
                ctrl_o.act_rd_addr = ofmap_start_q + rd_ptr_q;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers, rewound on every state exit
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wt_ptr_q       <= '0;
            act_wr_ptr_q   <= '0;
            ofmap_start_q  <= '0;
            out_ptr_q      <= '0;
            rd_ptr_q       <= '0;
            tap_valid_q    <= 1'b0;
            tap_last_q     <= 1'b0;
            bus_rd_valid_q <= 1'b0;
        end else if (clear_i) begin
            wt_ptr_q       <= '0;
            act_wr_ptr_q   <= '0;
            ofmap_start_q  <= '0;
            out_ptr_q      <= '0;
            rd_ptr_q       <= '0;
            tap_valid_q    <= 1'b0;
            tap_last_q     <= 1'b0;
            bus_rd_valid_q <= 1'b0;
        end else begin
            // Align with the registered memory reads
            tap_valid_q    <= issuing;
            tap_last_q     <= issuing && window_end;
            bus_rd_valid_q <= (state_q == s_read_acts) && bus_rd;
            case (state_q)
                s_load_weights: begin
                    if (leaving) wt_ptr_q <= '0;
                    else if (bus_wr) wt_ptr_q <= wt_ptr_q + 1'b1;
                end
                s_load_acts: begin
                    if (leaving) begin
                        act_wr_ptr_q  <= '0;
                        ofmap_start_q <= act_wr_ptr_q + act_addr_width'(elems_per_word);
                    end else if (bus_wr) begin
                        act_wr_ptr_q <= act_wr_ptr_q + act_addr_width'(elems_per_word);
                    end
                end
                s_compute: begin
                    if (leaving) out_ptr_q <= '0;
                    else if (result_valid_i) out_ptr_q <= out_ptr_q + 1'b1;
                end
                s_read_acts: begin
                    if (leaving) rd_ptr_q <= '0;
                    else if (bus_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Window counters, fx fastest and oy slowest
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            {fx_q, fy_q, ox_q, oy_q} <= '0;
            issue_done_q <= 1'b0;
        end else if (clear_i || state_q != s_compute) begin
            {fx_q, fy_q, ox_q, oy_q} <= '0;
            issue_done_q <= 1'b0;
        end else if (!issue_done_q) begin
            if (fx_q != cfg_i.filter_x - 3'd1) begin
                fx_q <= fx_q + 3'd1;
            end else begin
                fx_q <= '0;
                if (fy_q != cfg_i.filter_y - 3'd1) begin
                    fy_q <= fy_q + 3'd1;
                end else begin
                    fy_q <= '0;
                    if (ox_q != out_x - 4'd1) begin
                        ox_q <= ox_q + 4'd1;
                    end else begin
                        ox_q <= '0;
                        if (oy_q != out_y - 4'd1) begin
                            oy_q <= oy_q + 4'd1;
                        end else begin
                            oy_q         <= '0;
                            issue_done_q <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/qracc_act_buffer.sv
/* Byte-addressed activation memory with a word-wide host write,
   a byte-wide result write and one registered byte read */
`default_nettype none

module qracc_act_buffer import qracc_pkg::*; (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      ext_wr_en_i,
    input  logic [act_addr_width-1:0] ext_wr_addr_i,
    input  logic [bus_width-1:0]      ext_wr_data_i,
    input  logic                      int_wr_en_i,
    input  logic [act_addr_width-1:0] int_wr_addr_i,
    input  logic [act_width-1:0]      int_wr_data_i,
    input  logic                      rd_en_i,
    input  logic [act_addr_width-1:0] rd_addr_i,
    output logic [act_width-1:0]      rd_data_o
);

    logic [act_width-1:0] mem [act_depth];
    logic [act_width-1:0] rd_data_q;

    // Host word is little-endian, element 0 in the low byte
    always_ff @(posedge clk) begin
        if (ext_wr_en_i) begin
            for (int i = 0; i < elems_per_word; i++) begin
                mem[ext_wr_addr_i + act_addr_width'(i)] <= ext_wr_data_i[i*act_width +: act_width];
            end
        end
        if (int_wr_en_i) begin
            mem[int_wr_addr_i] <= int_wr_data_i;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_data_q <= '0;
        end else if (rd_en_i) begin
            rd_data_q <= mem[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- source/qracc_weight_mem.sv
/* Filter weight memory, one byte per tap, registered read */
`default_nettype none

module qracc_weight_mem import qracc_pkg::*; (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     wr_en_i,
    input  logic [wt_addr_width-1:0] wr_addr_i,
    input  logic [act_width-1:0]     wr_data_i,
    input  logic [wt_addr_width-1:0] rd_addr_i,
    output logic [act_width-1:0]     rd_data_o
);

    logic [act_width-1:0] mem [max_taps];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Read every cycle, the MAC only looks at it on valid taps
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- source/qracc_mac_engine.sv
/* Signed multiply-accumulate over the taps of one output window */
`default_nettype none

module qracc_mac_engine import qracc_pkg::*; (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 clear_i,
    input  logic                 tap_valid_i,
    input  logic                 tap_last_i,
    input  logic [act_width-1:0] act_i,
    input  logic [act_width-1:0] weight_i,
    output logic [acc_width-1:0] sum_o,
    output logic                 sum_valid_o
);

    logic signed [2*act_width-1:0] product;
    logic signed [acc_width-1:0]   acc_q;
    logic signed [acc_width-1:0]   acc_next;
    logic                          sum_valid_q;
    logic [acc_width-1:0]          sum_q;

    assign product  = $signed(act_i) * $signed(weight_i);
    assign acc_next = acc_q + acc_width'(product);

    ////////////////////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            acc_q       <= '0;
            sum_valid_q <= 1'b0;
        end else if (clear_i) begin
            acc_q       <= '0;
            sum_valid_q <= 1'b0;
        end else begin
            sum_valid_q <= tap_valid_i && tap_last_i;
            if (tap_valid_i) begin
                // Restart so the next window follows without a gap
                acc_q <= tap_last_i ? '0 : acc_next;
            end
        end
    end

    // Finished window sum
    always_ff @(posedge clk) begin
        if (tap_valid_i && tap_last_i) begin
            sum_q <= acc_next;
        end
    end

    assign sum_o       = sum_q;
    assign sum_valid_o = sum_valid_q;

endmodule

`default_nettype wire

//--- source/qracc_output_scaler.sv
/* Scale word register and the scale, shift and saturate stage */
`default_nettype none

module qracc_output_scaler import qracc_pkg::*; (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 clear_i,
    input  logic                 scale_wr_en_i,
    input  logic [11:0]          scale_data_i,
    input  logic [acc_width-1:0] sum_i,
    input  logic                 sum_valid_i,
    output logic [act_width-1:0] result_o,
    output logic                 result_valid_o
);

    logic [7:0] scale_q;
    logic [3:0] shift_q;
    logic signed [acc_width+8:0] scaled;
    logic [act_width-1:0] sat;

    // Scale is unsigned, so widen it with a zero sign bit
    assign scaled = ($signed(sum_i) * $signed({1'b0, scale_q})) >>> shift_q;

    always_comb begin
        if (scaled > 127) sat = 8'h7f;
        else if (scaled < -128) sat = 8'h80;
        else sat = scaled[act_width-1:0];
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            {shift_q, scale_q} <= '0;
            result_valid_o     <= 1'b0;
        end else if (clear_i) begin
            {shift_q, scale_q} <= '0;
            result_valid_o     <= 1'b0;
        end else begin
            if (scale_wr_en_i) {shift_q, scale_q} <= scale_data_i;
            result_valid_o <= sum_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid_i) result_o <= sat;
    end

endmodule

`default_nettype wire

//--- source/qracc_top.sv
/* Accelerator core top, sequencer with memories and datapath */
`default_nettype none

module qracc_top import qracc_pkg::*; (
    input  logic                 clk,
    input  logic                 nrst,
    input  qracc_cfg_t           cfg_i,
    input  logic                 start_i,
    input  logic                 clear_i,
    input  qracc_bus_t           bus_i,
    output logic [bus_width-1:0] bus_rd_data_o,
    output logic                 bus_rd_valid_o,
    output logic                 busy_o
);

    qracc_ctrl_t          ctrl;
    logic [act_width-1:0] act_rd_data;
    logic [act_width-1:0] wt_rd_data;
    logic [acc_width-1:0] sum;
    logic                 sum_valid;
    logic [act_width-1:0] result;
    logic                 result_valid;

    qracc_controller i_controller (
        .clk, .nrst, .cfg_i, .start_i, .clear_i, .bus_i,
        .result_valid_i (result_valid),
        .ctrl_o         (ctrl),
        .bus_rd_valid_o,
        .busy_o
    );

    qracc_act_buffer i_act_buffer (
        .clk, .nrst,
        .ext_wr_en_i   (ctrl.act_ext_wr_en),
        .ext_wr_addr_i (ctrl.act_ext_wr_addr),
        .ext_wr_data_i (bus_i.wdata),
        .int_wr_en_i   (result_valid),
        .int_wr_addr_i (ctrl.act_int_wr_addr),
        .int_wr_data_i (result),
        .rd_en_i       (ctrl.act_rd_en),
        .rd_addr_i     (ctrl.act_rd_addr),
        .rd_data_o     (act_rd_data)
    );

    qracc_weight_mem i_weight_mem (
        .clk, .nrst,
        .wr_en_i   (ctrl.wt_wr_en),
        .wr_addr_i (ctrl.wt_wr_addr),
        .wr_data_i (bus_i.wdata[act_width-1:0]),
        .rd_addr_i (ctrl.wt_rd_addr),
        .rd_data_o (wt_rd_data)
    );

    qracc_mac_engine i_mac_engine (
        .clk, .nrst, .clear_i,
        .tap_valid_i (ctrl.tap_valid),
        .tap_last_i  (ctrl.tap_last),
        .act_i       (act_rd_data),
        .weight_i    (wt_rd_data),
        .sum_o       (sum),
        .sum_valid_o (sum_valid)
    );

    qracc_output_scaler i_output_scaler (
        .clk, .nrst, .clear_i,
        .scale_wr_en_i  (ctrl.scaler_wr_en),
        .scale_data_i   (bus_i.wdata[11:0]),
        .sum_i          (sum),
        .sum_valid_i    (sum_valid),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

    // Output byte sign-extended onto the bus
    assign bus_rd_data_o = {{(bus_width-act_width){act_rd_data[act_width-1]}}, act_rd_data};

endmodule

`default_nettype wire

//--- tb/qracc_tb.sv
/* Testbench for the convolution core with a host bus driver, a
   reference convolution and a comparing process on the read-out */
`default_nettype none

module qracc_tb import qracc_pkg::*; ();

    // The 4x4 filter over a 10x10 map is the longest job and fits in job_limit
    localparam int job_limit      = 1200;
    localparam int n_jobs         = 8;
    localparam int timeout_cycles = n_jobs * job_limit + 400;

    logic                 clk;
    logic                 nrst;
    qracc_cfg_t           cfg;
    logic                 start;
    logic                 clear;
    qracc_bus_t           bus;
    logic [bus_width-1:0] bus_rd_data;
    logic                 bus_rd_valid;
    logic                 busy;

    integer seed = 51995;
    int cycle_count = 0;
    int dim_x;
    int dim_y;
    int flt_x;
    int flt_y;
    int scale;
    int shift;
    logic [act_width-1:0] act_img [act_depth];
    logic [act_width-1:0] wt_img [max_taps];
    logic [act_width-1:0] exp_q [$];
    logic reading = 1'b0;
    logic rd_expect = 1'b0;

    qracc_top i_dut (
        .clk            (clk),
        .nrst           (nrst),
        .cfg_i          (cfg),
        .start_i        (start),
        .clear_i        (clear),
        .bus_i          (bus),
        .bus_rd_data_o  (bus_rd_data),
        .bus_rd_valid_o (bus_rd_valid),
        .busy_o         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Error reporting and checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        assert (got == expected) else
            stop_on_error($sformatf("FAILED %s expected %h got %h", name, expected, got));
    endtask

    // Convolve, scale, shift and saturate one output pixel
    function automatic logic [act_width-1:0] ref_pixel(input int ox, input int oy);
        longint acc;
        longint scaled;
        int x;
        int y;
        acc = 0;
        for (y = 0; y < flt_y; y++) begin
            for (x = 0; x < flt_x; x++) begin
                acc += longint'($signed(act_img[(oy + y) * dim_x + ox + x]))
                     * longint'($signed(wt_img[y * flt_x + x]));
            end
        end
        scaled = (acc * scale) >>> shift;
        if (scaled > 127) return 8'h7f;
        if (scaled < -128) return 8'h80;
        return scaled[act_width-1:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Job setup
    ////////////////////////////////////////////////////////////////////////////
    task automatic set_shape(input int dx, input int dy, input int kx, input int ky);
        dim_x = dx;
        dim_y = dy;
        flt_x = kx;
        flt_y = ky;
        for (int i = 0; i < act_depth; i++) act_img[i] = '0;
    endtask

    task automatic random_shape();
        set_shape(4 + {$random(seed)} % 7, 4 + {$random(seed)} % 7,
                  1 + {$random(seed)} % 4, 1 + {$random(seed)} % 4);
    endtask

    task automatic fill_random();
        for (int i = 0; i < dim_x * dim_y; i++) act_img[i] = 8'($random(seed));
        for (int i = 0; i < flt_x * flt_y; i++) wt_img[i] = 8'($random(seed));
        scale = {$random(seed)} % 256;
        shift = {$random(seed)} % 16;
    endtask

    task automatic fill_const(input logic [7:0] act_val, input logic [7:0] wt_val,
                              input int sc, input int sh);
        for (int i = 0; i < dim_x * dim_y; i++) act_img[i] = act_val;
        for (int i = 0; i < flt_x * flt_y; i++) wt_img[i] = wt_val;
        scale = sc;
        shift = sh;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host bus driver
    ////////////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic write_word(input logic [bus_width-1:0] data);
        next_cycle();
        bus.valid = 1'b1;
        bus.wen   = 1'b1;
        bus.wdata = data;
    endtask

    task automatic run_job(input bit abort_load);
        int n_words;
        int n_out;
        logic [bus_width-1:0] word;
        n_words = (dim_x * dim_y + elems_per_word - 1) / elems_per_word;
        n_out   = (dim_x - flt_x + 1) * (dim_y - flt_y + 1);
        cfg.ifmap_dimx = 4'(dim_x);
        cfg.ifmap_dimy = 4'(dim_y);
        cfg.filter_x   = 3'(flt_x);
        cfg.filter_y   = 3'(flt_y);
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_value("busy_o", 32'd1, 32'(busy));
        // Only the low byte carries the weight
        for (int i = 0; i < flt_x * flt_y; i++) begin
            word = $random(seed);
            word[7:0] = wt_img[i];
            write_word(word);
        end
        for (int i = 0; i < n_words; i++) begin
            if (abort_load && i == n_words / 2) begin
                next_cycle();
                bus   = '0;
                clear = 1'b1;
                next_cycle();
                clear = 1'b0;
                check_value("busy_o", 32'd0, 32'(busy));
                return;
            end
            word = {act_img[4*i+3], act_img[4*i+2], act_img[4*i+1], act_img[4*i]};
            write_word(word);
        end
        word = $random(seed);
        word[11:0] = {4'(shift), 8'(scale)};
        write_word(word);
        next_cycle();
        bus = '0;
        while (i_dut.i_controller.state_q != s_read_acts) next_cycle();

        for (int oy = 0; oy <= dim_y - flt_y; oy++) begin
            for (int ox = 0; ox <= dim_x - flt_x; ox++) begin
                exp_q.push_back(ref_pixel(ox, oy));
            end
        end
        reading = 1'b1;
        for (int i = 0; i < n_out; i++) begin
            next_cycle();
            bus.valid = 1'b1;
            bus.wen   = 1'b0;
            bus.wdata = $random(seed);
        end
        next_cycle();
        bus     = '0;
        reading = 1'b0;
        check_value("busy_o", 32'd0, 32'(busy));
        next_cycle();
        assert (exp_q.size() == 0) else
            stop_on_error("Not every output pixel came back on the read bus");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Comparing process and timeout
    ////////////////////////////////////////////////////////////////////////////
    // Read data is due one cycle after each strobe
    always @(posedge clk) begin
        rd_expect <= reading && bus.valid && !bus.wen;
    end

    always @(negedge clk) begin
        if (nrst) begin
            check_value("bus_rd_valid_o", 32'(rd_expect), 32'(bus_rd_valid));
            if (bus_rd_valid) begin
                assert (exp_q.size() > 0) else
                    stop_on_error("Read data arrived with no output pixel left to expect");
                check_value("bus_rd_data_o", {{24{exp_q[0][7]}}, exp_q[0]}, bus_rd_data);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            stop_on_error($sformatf("Timeout, the run did not end within %0d cycles",
                                    timeout_cycles));
        end
    end

    initial begin
        nrst  = 1'b0;
        cfg   = '0;
        start = 1'b0;
        clear = 1'b0;
        bus   = '0;
        repeat (5) @(posedge clk);
        #10;
        nrst = 1'b1;
        check_value("busy_o", 32'd0, 32'(busy));
        check_value("bus_rd_valid_o", 32'd0, 32'(bus_rd_valid));

        set_shape(8, 8, 3, 3);
        fill_random();
        run_job(1'b0);
        // Saturation at both ends
        set_shape(6, 6, 3, 3);
        fill_const(8'd127, 8'd127, 255, 0);
        run_job(1'b0);
        fill_const(8'd127, 8'h80, 255, 0);
        run_job(1'b0);
        // Smallest and largest window shapes
        set_shape(4, 4, 1, 1);
        fill_random();
        run_job(1'b0);
        set_shape(10, 10, 4, 4);
        fill_random();
        run_job(1'b0);
        random_shape();
        fill_random();
        run_job(1'b0);
        // Abort during the activation load and run a clean job after it
        random_shape();
        fill_random();
        run_job(1'b1);
        random_shape();
        fill_random();
        run_job(1'b0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- qracc_top.f
source/qracc_pkg.sv
source/qracc_controller.sv
source/qracc_act_buffer.sv
source/qracc_weight_mem.sv
source/qracc_mac_engine.sv
source/qracc_output_scaler.sv
source/qracc_top.sv
tb/qracc_tb.sv

//--- Makefile
# Verilator flow for the convolution core

VERILATOR ?= verilator
TB_TOP    ?= qracc_tb
RTL_TOP   ?= qracc_top
FILELIST  ?= qracc_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall -Wno-fatal

SRCS    := $(wildcard source/*.sv tb/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
